//--- rename_pkg.sv
`default_nettype none

package rename_pkg;

    // core sizes
    localparam int retire_width = 2;
    localparam int arch_regs    = 32;
    localparam int phys_regs    = 64;
    localparam int free_regs    = phys_regs - arch_regs;

    typedef logic [4:0] arn_t;
    typedef logic [5:0] prn_t;
    typedef logic [4:0] free_ptr_t;   // index into the free ring
    typedef logic [5:0] free_count_t; // 0 .. free_regs

    // one retiring instruction
    typedef struct packed {
        logic valid;
        logic success;
        arn_t arn;
    } retire_lane_t;

    // lane 0 is the oldest
    typedef struct packed {
        retire_lane_t [retire_width-1:0] lane;
    } retire_bundle_t;

    // push request or pop result
    typedef struct packed {
        logic valid;
        prn_t prn;
    } free_packet_t;

    // committed state handed back to the front end
    typedef struct packed {
        logic                       squash;
        prn_t [arch_regs-1:0]       map;
        free_ptr_t                  head;
        free_ptr_t                  tail;
        free_count_t                count;
    } recovery_t;

    typedef logic [11:0] axil_addr_t;
    typedef logic [31:0] axil_data_t;

    typedef enum logic [1:0] {
        OKAY   = 2'd0,
        SLVERR = 2'd2
    } axil_resp_e;

    typedef struct packed {
        logic       awvalid;
        axil_addr_t awaddr;
        logic       wvalid;
        axil_data_t wdata;
        logic       bready;
        logic       arvalid;
        axil_addr_t araddr;
        logic       rready;
    } axil_req_t;

    typedef struct packed {
        logic       awready;
        logic       wready;
        logic       bvalid;
        axil_resp_e bresp;
        logic       arready;
        logic       rvalid;
        axil_data_t rdata;
        axil_resp_e rresp;
    } axil_rsp_t;

    // debug register map
    localparam axil_addr_t addr_retired    = 12'h000;
    localparam axil_addr_t addr_squashes   = 12'h004;
    localparam axil_addr_t addr_free_count = 12'h008;
    localparam axil_addr_t addr_map_base   = 12'h100;
    localparam axil_addr_t addr_map_end    = addr_map_base + axil_addr_t'(4 * arch_regs);

endpackage

`default_nettype wire

//--- rrat_free_list.sv
`timescale 1ns/1ps
`default_nettype none

module rrat_free_list (
    input  logic                                                     clock,
    input  logic                                                     reset,
    input  rename_pkg::free_packet_t [rename_pkg::retire_width-1:0] push,
    input  logic [rename_pkg::retire_width-1:0]                      pop_en,
    output rename_pkg::free_packet_t [rename_pkg::retire_width-1:0] pop,
    output rename_pkg::free_ptr_t                                    head,
    output rename_pkg::free_ptr_t                                    tail,
    output rename_pkg::free_count_t                                  count
);
    import rename_pkg::*;

    prn_t        ring [free_regs];
    free_count_t num_pop;
    free_count_t num_push;
    free_ptr_t   wr_idx [retire_width];

    // pops are served from the head in lane order, skipping idle lanes
    always_comb begin
        num_pop = '0;
        for (int i = 0; i < retire_width; i++) begin
            pop[i].prn   = ring[head + free_ptr_t'(num_pop)];
            pop[i].valid = pop_en[i] && (num_pop < count);
            if (pop[i].valid) begin
                num_pop = num_pop + 1'b1;
            end
        end
    end

    // each valid push takes the next slot after the tail
    always_comb begin
        num_push = '0;
        for (int i = 0; i < retire_width; i++) begin
            wr_idx[i] = tail + free_ptr_t'(num_push);
            if (push[i].valid) begin
                num_push = num_push + 1'b1;
            end
        end
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            head  <= '0;
            tail  <= '0;
            count <= free_count_t'(free_regs);
            for (int i = 0; i < free_regs; i++) begin
                ring[i] <= prn_t'(arch_regs + i); // prn 32..63 free at start
            end
        end else begin
            head  <= head + free_ptr_t'(num_pop);
            tail  <= tail + free_ptr_t'(num_push);
            count <= count + num_push - num_pop;
            for (int i = 0; i < retire_width; i++) begin
                if (push[i].valid) begin
                    ring[wr_idx[i]] <= push[i].prn;
                end
            end
        end
    end

    // occupancy can never grow past the ring size
    assert property (@(posedge clock) disable iff (reset)
        count <= free_count_t'(free_regs))
        else $error("free list count %0d above %0d", count, free_regs);

    // the alias table only asks for a register it can get
    for (genvar i = 0; i < retire_width; i++) begin : g_pop_check
        assert property (@(posedge clock) disable iff (reset)
            pop_en[i] |-> pop[i].valid)
            else $error("pop on lane %0d with count %0d", i, count);
    end

endmodule

`default_nettype wire

//--- rrat.sv
`timescale 1ns/1ps
`default_nettype none

module rrat (
    input  logic                       clock,
    input  logic                       reset,
    input  rename_pkg::retire_bundle_t retire,
    output rename_pkg::recovery_t      recovery,
    output logic [1:0]                 commit_count,
    output logic                       squash_event
);
    import rename_pkg::*;

    prn_t [arch_regs-1:0]            map_q;
    prn_t [arch_regs-1:0]            map_next;
    logic                            squash_q;
    logic                            lane_open;
    logic [retire_width-1:0]         pop_en;
    free_packet_t [retire_width-1:0] push;
    free_packet_t [retire_width-1:0] pop;
    free_ptr_t                       fl_head;
    free_ptr_t                       fl_tail;
    free_count_t                     fl_count;

    rrat_free_list u_free_list (
        .clock  (clock),
        .reset  (reset),
        .push   (push),
        .pop_en (pop_en),
        .pop    (pop),
        .head   (fl_head),
        .tail   (fl_tail),
        .count  (fl_count)
    );

    // commit mask, oldest lane first
    always_comb begin
        lane_open    = 1'b1;
        pop_en       = '0;
        commit_count = '0;
        squash_event = 1'b0;
        for (int i = 0; i < retire_width; i++) begin
            lane_open = lane_open && retire.lane[i].valid;
            pop_en[i] = lane_open && (retire.lane[i].arn != '0); // r0 never renamed
            if (lane_open) begin
                commit_count = commit_count + 1'b1;
                squash_event = !retire.lane[i].success;
            end
            lane_open = lane_open && retire.lane[i].success;
        end
    end

    // later lanes see the map as left by earlier lanes
    always_comb begin
        map_next = map_q;
        for (int i = 0; i < retire_width; i++) begin
            push[i].valid = pop_en[i];
            push[i].prn   = map_next[retire.lane[i].arn];
            if (pop_en[i]) begin
                map_next[retire.lane[i].arn] = pop[i].prn;
            end
        end
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            squash_q <= 1'b0;
            for (int i = 0; i < arch_regs; i++) begin
                map_q[i] <= prn_t'(i); // identity map
            end
        end else begin
            squash_q <= squash_event;
            map_q    <= map_next;
        end
    end

    assign recovery = '{squash: squash_q, map: map_q, head: fl_head,
                        tail: fl_tail, count: fl_count};

    // r0 stays pinned to prn 0 across every commit
    assert property (@(posedge clock) disable iff (reset) map_q[0] == '0)
        else $error("r0 remapped to prn %0d", map_q[0]);

endmodule

`default_nettype wire

//--- rename_debug_regs.sv
`timescale 1ns/1ps
`default_nettype none

module rename_debug_regs (
    input  logic                                            clock,
    input  logic                                            reset,
    input  rename_pkg::axil_req_t                           host,
    output rename_pkg::axil_rsp_t                           host_rsp,
    input  logic [1:0]                                      commit_count,
    input  logic                                            squash_event,
    input  rename_pkg::prn_t [rename_pkg::arch_regs-1:0]    map,
    input  rename_pkg::free_count_t                         free_count
);
    import rename_pkg::*;

    logic       wr_ready_q;
    logic       bvalid_q;
    axil_resp_e bresp_q;
    logic       ar_ready_q;
    logic       rvalid_q;
    axil_data_t rdata_q;
    axil_resp_e rresp_q;
    logic [31:0] retired;
    logic [31:0] squashes;
    logic       wr_hs;
    logic       rd_hs;
    logic       clear;
    arn_t       map_idx;
    axil_data_t rd_data;
    axil_resp_e rd_resp;

    assign wr_hs   = wr_ready_q && host.awvalid && host.wvalid;
    assign rd_hs   = ar_ready_q && host.arvalid;
    assign clear   = wr_hs && (host.awaddr == addr_retired);
    assign map_idx = arn_t'((host.araddr - addr_map_base) >> 2);

    // read decode
    always_comb begin
        rd_data = '0;
        rd_resp = OKAY;
        if (host.araddr >= addr_map_base && host.araddr < addr_map_end &&
            host.araddr[1:0] == 2'b00) begin
            rd_data = axil_data_t'(map[map_idx]);
        end else begin
            case (host.araddr)
                addr_retired:    rd_data = retired;
                addr_squashes:   rd_data = squashes;
                addr_free_count: rd_data = axil_data_t'(free_count);
                default:         rd_resp = SLVERR;
            endcase
        end
    end

    // write channel, aw and w taken together
    always_ff @(posedge clock) begin
        if (reset) begin
            wr_ready_q <= 1'b0;
            bvalid_q   <= 1'b0;
        end else begin
            wr_ready_q <= host.awvalid && host.wvalid && !wr_ready_q && !bvalid_q;
            if (wr_hs) begin
                bvalid_q <= 1'b1;
            end else if (host.bready) begin
                bvalid_q <= 1'b0;
            end
        end
    end

    always_ff @(posedge clock) begin
        if (wr_hs) begin
            bresp_q <= (host.awaddr == addr_retired) ? OKAY : SLVERR;
        end
    end

    // read channel
    always_ff @(posedge clock) begin
        if (reset) begin
            ar_ready_q <= 1'b0;
            rvalid_q   <= 1'b0;
        end else begin
            ar_ready_q <= host.arvalid && !ar_ready_q && !rvalid_q;
            if (rd_hs) begin
                rvalid_q <= 1'b1;
            end else if (host.rready) begin
                rvalid_q <= 1'b0;
            end
        end
    end

    always_ff @(posedge clock) begin
        if (rd_hs) begin // sample at the ar handshake
            rdata_q <= rd_data;
            rresp_q <= rd_resp;
        end
    end

    always_ff @(posedge clock) begin
        if (reset || clear) begin // a clear drops this cycle's increments
            retired  <= '0;
            squashes <= '0;
        end else begin
            retired  <= retired + 32'(commit_count);
            squashes <= squashes + 32'(squash_event);
        end
    end

    assign host_rsp = '{awready: wr_ready_q, wready: wr_ready_q, bvalid: bvalid_q,
                        bresp: bresp_q, arready: ar_ready_q, rvalid: rvalid_q,
                        rdata: rdata_q, rresp: rresp_q};

    assert property (@(posedge clock) disable iff (reset)
        host_rsp.rvalid && !host.rready |=> $stable(host_rsp.rdata))
        else $error("rdata changed under back-pressure");

endmodule

`default_nettype wire

//--- arch_rename_top.sv
`timescale 1ns/1ps
`default_nettype none

module arch_rename_top (
    input  logic                       clock,
    input  logic                       reset,
    input  rename_pkg::retire_bundle_t retire,
    input  rename_pkg::axil_req_t      host,
    output rename_pkg::recovery_t      recovery,
    output rename_pkg::axil_rsp_t      host_rsp
);
    import rename_pkg::*;

    logic [1:0] commit_count; // lanes committed this cycle
    logic       squash_event;

    rrat u_rrat (
        .clock        (clock),
        .reset        (reset),
        .retire       (retire),
        .recovery     (recovery),
        .commit_count (commit_count),
        .squash_event (squash_event)
    );

    // host view of the committed state
    rename_debug_regs u_debug_regs (
        .clock        (clock),
        .reset        (reset),
        .host         (host),
        .host_rsp     (host_rsp),
        .commit_count (commit_count),
        .squash_event (squash_event),
        .map          (recovery.map),
        .free_count   (recovery.count)
    );

endmodule

`default_nettype wire

//--- tb_arch_rename.sv
`timescale 1ns/1ps
`default_nettype none

module tb_arch_rename;
    import rename_pkg::*;

    localparam int wait_limit = 50;

    logic           clock;
    logic           reset;
    retire_bundle_t retire;
    axil_req_t      host;
    recovery_t      recovery;
    axil_rsp_t      host_rsp;

    // reference model of the committed state
    prn_t [arch_regs-1:0] model_map;
    prn_t                 free_q [$];
    free_ptr_t            model_head;
    free_ptr_t            model_tail;
    free_count_t          model_count;
    logic                 model_squash;
    logic [31:0]          model_retired;
    logic [31:0]          model_squashes;

    axil_data_t exp_rdata;
    axil_resp_e exp_rresp;
    axil_resp_e exp_bresp;
    string      test_name;
    int         errors;

    arch_rename_top DUT (
        .clock    (clock),
        .reset    (reset),
        .retire   (retire),
        .host     (host),
        .recovery (recovery),
        .host_rsp (host_rsp)
    );

    always #10 clock = ~clock;

    always @(posedge clock) begin
        prn_t [arch_regs-1:0] m;
        prn_t                 p;
        logic                 lane_open;
        logic                 fail;
        int                   committed;
        int                   moved;
        if (reset) begin
            free_q.delete();
            for (int i = 0; i < free_regs; i++) begin
                free_q.push_back(prn_t'(arch_regs + i));
            end
            for (int i = 0; i < arch_regs; i++) begin
                m[i] = prn_t'(i);
            end
            model_map      <= m;
            model_head     <= '0;
            model_tail     <= '0;
            model_count    <= free_count_t'(free_regs);
            model_squash   <= 1'b0;
            model_retired  <= '0;
            model_squashes <= '0;
        end else begin
            m         = model_map;
            lane_open = 1'b1;
            fail      = 1'b0;
            committed = 0;
            moved     = 0;
            for (int i = 0; i < retire_width; i++) begin
                if (lane_open && retire.lane[i].valid) begin
                    committed++;
                    fail = !retire.lane[i].success;
                    if (retire.lane[i].arn != '0) begin
                        p = free_q.pop_front(); // oldest free register
                        free_q.push_back(m[retire.lane[i].arn]);
                        m[retire.lane[i].arn] = p;
                        moved++;
                    end
                    lane_open = retire.lane[i].success;
                end else begin
                    lane_open = 1'b0;
                end
            end
            model_map    <= m;
            model_head   <= model_head + free_ptr_t'(moved);
            model_tail   <= model_tail + free_ptr_t'(moved);
            model_count  <= free_count_t'(free_q.size());
            model_squash <= fail;
            if (host_rsp.awready && host.awvalid && host.wvalid &&
                host.awaddr == addr_retired) begin
                model_retired  <= '0;  // clear wins over this cycle's retires
                model_squashes <= '0;
            end else begin
                model_retired  <= model_retired + 32'(committed);
                model_squashes <= model_squashes + 32'(fail);
            end
        end
    end

    assert property (@(posedge clock) disable iff (reset) recovery.map == model_map)
        else begin
            errors++;
            $display("ERROR %s map: expected %h actual %h", test_name,
                     $sampled(model_map), $sampled(recovery.map));
        end

    assert property (@(posedge clock) disable iff (reset) recovery.squash == model_squash)
        else begin
            errors++;
            $display("ERROR %s squash: expected %b actual %b", test_name,
                     $sampled(model_squash), $sampled(recovery.squash));
        end

    assert property (@(posedge clock) disable iff (reset)
        recovery.head == model_head && recovery.tail == model_tail &&
        recovery.count == model_count)
        else begin
            errors++;
            $display("ERROR %s head/tail/count: expected %0d/%0d/%0d actual %0d/%0d/%0d",
                     test_name, $sampled(model_head), $sampled(model_tail),
                     $sampled(model_count), $sampled(recovery.head),
                     $sampled(recovery.tail), $sampled(recovery.count));
        end

    // read response checked when it is taken
    assert property (@(posedge clock) disable iff (reset)
        host_rsp.rvalid && host.rready |->
            host_rsp.rdata == exp_rdata && host_rsp.rresp == exp_rresp)
        else begin
            errors++;
            $display("ERROR %s read: expected %h/%0d actual %h/%0d", test_name,
                     $sampled(exp_rdata), $sampled(exp_rresp),
                     $sampled(host_rsp.rdata), $sampled(host_rsp.rresp));
        end

    assert property (@(posedge clock) disable iff (reset)
        host_rsp.bvalid && host.bready |-> host_rsp.bresp == exp_bresp)
        else begin
            errors++;
            $display("ERROR %s bresp: expected %0d actual %0d", test_name,
                     $sampled(exp_bresp), $sampled(host_rsp.bresp));
        end

    // aw and w are accepted in the same cycle
    assert property (@(posedge clock) disable iff (reset)
        host_rsp.awready == host_rsp.wready)
        else begin
            errors++;
            $display("awready and wready were not raised together");
        end

    assert property (@(posedge clock) disable iff (reset)
        host_rsp.rvalid && !host.rready |=> host_rsp.rvalid && $stable(host_rsp.rdata))
        else begin
            errors++;
            $display("read response dropped or changed while rready was low");
        end

    assert property (@(posedge clock) disable iff (reset) host_rsp.rvalid |-> !host_rsp.arready)
        else begin
            errors++;
            $display("new read accepted while a read response was pending");
        end

    assert property (@(posedge clock) disable iff (reset)
        host_rsp.bvalid && !host.bready |=> host_rsp.bvalid)
        else begin
            errors++;
            $display("write response dropped while bready was low");
        end

    function automatic retire_lane_t make_lane(input logic valid, input logic success,
                                               input int arn);
        retire_lane_t l;
        l.valid   = valid;
        l.success = success;
        l.arn     = arn_t'(arn);
        return l;
    endfunction

    function automatic retire_lane_t random_lane();
        retire_lane_t l;
        l.valid   = ($urandom % 10) != 0;
        l.success = ($urandom % 10) != 0;
        l.arn     = arn_t'($urandom);
        return l;
    endfunction

    task automatic drive_lanes(input retire_lane_t l0, input retire_lane_t l1);
        retire.lane[0] = l0;
        retire.lane[1] = l1;
        @(negedge clock);
    endtask

    // expected read data from the model at the ar handshake
    task automatic set_expected(input axil_addr_t addr);
        exp_rdata = '0;
        exp_rresp = OKAY;
        if (addr >= addr_map_base && addr < addr_map_end && addr[1:0] == 2'b00) begin
            exp_rdata = axil_data_t'(model_map[arn_t'((addr - addr_map_base) >> 2)]);
        end else if (addr == addr_retired) begin
            exp_rdata = model_retired;
        end else if (addr == addr_squashes) begin
            exp_rdata = model_squashes;
        end else if (addr == addr_free_count) begin
            exp_rdata = axil_data_t'(model_count);
        end else begin
            exp_rresp = SLVERR;
        end
    endtask

    task automatic read_reg(input axil_addr_t addr, input int stall);
        int t;
        host.arvalid = 1'b1;
        host.araddr  = addr;
        host.rready  = (stall == 0);
        for (t = 0; t < wait_limit && !host_rsp.arready; t++) begin
            @(negedge clock);
        end
        if (!host_rsp.arready) begin
            errors++;
            $display("timeout: read of 0x%h was never accepted", addr);
        end
        set_expected(addr);
        @(negedge clock);
        host.arvalid = 1'b0;
        for (t = 0; t < wait_limit && !host_rsp.rvalid; t++) begin
            @(negedge clock);
        end
        if (!host_rsp.rvalid) begin
            errors++;
            $display("timeout: no read response for 0x%h", addr);
        end
        if (stall > 0) begin
            host.arvalid = 1'b1; // must wait behind the stalled response
            host.araddr  = addr_free_count;
            repeat (stall) @(negedge clock);
            host.arvalid = 1'b0;
            host.rready  = 1'b1;
        end
        @(negedge clock);
    endtask

    task automatic write_reg(input axil_addr_t addr, input axil_data_t data, input int stall);
        int t;
        exp_bresp    = (addr == addr_retired) ? OKAY : SLVERR;
        host.awvalid = 1'b1;
        host.wvalid  = 1'b1;
        host.awaddr  = addr;
        host.wdata   = data;
        host.bready  = (stall == 0);
        for (t = 0; t < wait_limit && !host_rsp.awready; t++) begin
            @(negedge clock);
        end
        if (!host_rsp.awready) begin
            errors++;
            $display("timeout: write to 0x%h was never accepted", addr);
        end
        @(negedge clock);
        host.awvalid = 1'b0;
        host.wvalid  = 1'b0;
        for (t = 0; t < wait_limit && !host_rsp.bvalid; t++) begin
            @(negedge clock);
        end
        if (!host_rsp.bvalid) begin
            errors++;
            $display("timeout: no write response for 0x%h", addr);
        end
        repeat (stall) @(negedge clock);
        host.bready = 1'b1;
        @(negedge clock);
    endtask

    initial begin
        void'($urandom(64));
        clock     = 1'b0;
        reset     = 1'b1;
        retire    = '0;
        host      = '0;
        errors    = 0;
        test_name = "reset";
        repeat (4) @(negedge clock);
        reset = 1'b0;

        test_name = "reset_map";
        for (int i = 0; i < arch_regs; i++) begin
            read_reg(addr_map_base + axil_addr_t'(4 * i), 0);
        end
        read_reg(addr_free_count, 0);

        test_name = "random_retire";
        for (int c = 0; c < 200; c++) begin
            drive_lanes(random_lane(), random_lane());
        end
        drive_lanes('0, '0);

        test_name = "arn_zero";
        drive_lanes(make_lane(1, 1, 0), make_lane(1, 1, 0));
        drive_lanes(make_lane(1, 1, 0), make_lane(1, 1, 9));
        drive_lanes('0, '0);
        read_reg(addr_retired, 0);

        test_name = "fail_lane";
        drive_lanes(make_lane(1, 0, 5), make_lane(1, 1, 6));
        drive_lanes('0, '0); // squash shows here only
        drive_lanes(make_lane(0, 1, 7), make_lane(1, 1, 8));
        drive_lanes(make_lane(1, 1, 3), make_lane(1, 0, 4));
        drive_lanes('0, '0);
        drive_lanes('0, '0);

        test_name = "counters";
        read_reg(addr_retired, 0);
        read_reg(addr_squashes, 0);
        write_reg(addr_retired, 32'h0, 0);
        read_reg(addr_retired, 0);
        read_reg(addr_squashes, 0);
        read_reg(12'h00c, 0);
        write_reg(12'h010, 32'h1, 0);

        test_name = "back_pressure";
        read_reg(addr_map_base + 12'h00c, 5);
        write_reg(12'h020, 32'h5, 4);
        read_reg(addr_free_count, 0);

        $display("checks done, %0d errors", errors);
        if (errors == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- all.f
rename_pkg.sv
rrat_free_list.sv
rrat.sv
rename_debug_regs.sv
arch_rename_top.sv
tb_arch_rename.sv

//--- run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_arch_rename -f all.f -o sim_arch_rename

out=$(./obj_dir/sim_arch_rename)
echo "$out"

if echo "$out" | grep -qx "No errors"; then
    exit 0
fi
exit 1
